/* logic/fx_defs.svh */
// ################################################
// Width and format constants for the 8.8 unsigned
// fixed-point add/multiply pipeline. Included by the
// package and by every file that sizes a vector.
// ################################################

`ifndef FX_DEFS_SVH
`define FX_DEFS_SVH

// operand and result width
`define FX_WIDTH 16

// fraction bits, integer part is FX_WIDTH - FX_FRAC_BITS
`define FX_FRAC_BITS 8

// full product of two operands
`define FX_PROD_WIDTH 32

// partial products are reduced first into this many groups
// group k gathers multiplier bits k, k+4, k+8, k+12
`define FX_PP_GROUPS 4

`endif

/* logic/fx_pkg.sv */
// ################################################
// Shared vector types for the fixed-point pipeline.
// Stages, the stage interface and the top take the
// types from here.
// ################################################

`include "fx_defs.svh"

package fx_pkg;

  // 8.8 value, integer byte above fraction byte
  typedef logic [`FX_WIDTH-1:0] fx_word_t;

  // aligned to the full product
  // bits 23..8 line up with an 8.8 result
  typedef logic [`FX_PROD_WIDTH-1:0] fx_prod_t;

endpackage

/* logic/fx_stage_if.sv */
// ################################################
// One item in flight between the partial-product
// stage and the reduce stage, with its handshake.
// src drives the item, dst drives ready.
// ################################################

`timescale 1ns/1ns

`include "fx_defs.svh"

interface fx_stage_if;
  import fx_pkg::*;

  logic                            valid;
  logic                            ready;
  logic                            op_mul;    // 1 = multiply, 0 = add
  logic [`FX_WIDTH:0]              add_sum;   // sum with carry on top
  fx_prod_t [`FX_PP_GROUPS-1:0]    group_sum; // partial group sums

  modport src (
    output valid,
    output op_mul,
    output add_sum,
    output group_sum,
    input  ready
  );

  modport dst (
    input  valid,
    input  op_mul,
    input  add_sum,
    input  group_sum,
    output ready
  );

endinterface

/* logic/fx_partial_stage.sv */
// ################################################
// First pipeline slot. Builds the shifted partial
// products of num_a by each bit of num_b, folds them
// into group sums, and forms the raw 17-bit add.
// One register slot on a valid/ready stream.
// ################################################

`timescale 1ns/1ns

`include "fx_defs.svh"

module fx_partial_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  fx_pkg::fx_word_t num_a,
  input  fx_pkg::fx_word_t num_b,
  input  logic             op_mul,
  fx_stage_if.src          down
);
  import fx_pkg::*;

  fx_prod_t                     a_ext;              // multiplicand in product frame
  fx_prod_t                     pp [`FX_WIDTH];     // one per multiplier bit
  fx_prod_t [`FX_PP_GROUPS-1:0] grp;
  logic [`FX_WIDTH:0]           sum_ab;
  logic                         accept;

  assign a_ext = {{(`FX_PROD_WIDTH - `FX_WIDTH){1'b0}}, num_a};

  // shift and gate by multiplier bit
  always_comb
  begin
    for (int i = 0; i < `FX_WIDTH; i++)
    begin
      pp[i] = (a_ext << i) & {`FX_PROD_WIDTH{num_b[i]}};
    end
  end

  // group k takes bits k, k+4, k+8, k+12
  always_comb
  begin
    for (int k = 0; k < `FX_PP_GROUPS; k++)
    begin
      grp[k] = '0;
      for (int j = k; j < `FX_WIDTH; j += `FX_PP_GROUPS)
      begin
        grp[k] = grp[k] + pp[j];
      end
    end
  end

  assign sum_ab = {1'b0, num_a} + {1'b0, num_b}; // carry lands in the top bit

  // slot free, or its item leaves this edge
  assign in_ready = !down.valid || down.ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      down.valid <= 1'b0;
    else if (accept)
      down.valid <= 1'b1;
    else if (down.ready)
      down.valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      down.op_mul    <= op_mul;
      down.add_sum   <= sum_ab;
      down.group_sum <= grp;
    end
  end

  // a stalled item must not change under the reduce stage
  hold_on_stall_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    down.valid && !down.ready |=>
      down.valid && $stable(down.op_mul) && $stable(down.add_sum)
      && $stable(down.group_sum)
  ) else $error("partial stage item changed while stalled");

endmodule

/* logic/fx_reduce_stage.sv */
// ################################################
// Second pipeline slot. Adds the group sums into the
// full product, slices out the 8.8 result and sets
// the overflow and precision-lost flags, or passes
// the add result through. Registers on handshake.
// ################################################

`timescale 1ns/1ns

`include "fx_defs.svh"

module fx_reduce_stage (
  input  logic             clk,
  input  logic             rst_n,
  fx_stage_if.dst          up,
  output logic             out_valid,
  input  logic             out_ready,
  output fx_pkg::fx_word_t result,
  output logic             overflow,
  output logic             precision_lost
);
  import fx_pkg::*;

  fx_prod_t product;
  fx_word_t res_next;
  logic     ovf_next;
  logic     lost_next;
  logic     accept;

  // final reduction of the four groups
  always_comb
  begin
    product = '0;
    for (int k = 0; k < `FX_PP_GROUPS; k++)
    begin
      product = product + up.group_sum[k];
    end
  end

  always_comb
  begin
    if (up.op_mul)
    begin
      res_next  = product[`FX_FRAC_BITS +: `FX_WIDTH];                     // middle 16 bits
      ovf_next  = |product[`FX_PROD_WIDTH-1:`FX_WIDTH+`FX_FRAC_BITS];      // integer spill
      lost_next = |product[`FX_FRAC_BITS-1:0];                             // dropped fraction
    end
    else
    begin
      res_next  = up.add_sum[`FX_WIDTH-1:0];
      ovf_next  = up.add_sum[`FX_WIDTH];
      lost_next = 1'b0; // add is exact
    end
  end

  assign up.ready = !out_valid || out_ready;
  assign accept   = up.valid && up.ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else if (accept)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      result         <= res_next;
      overflow       <= ovf_next;
      precision_lost <= lost_next;
    end
  end

  // an accepted add shows up with precision_lost low
  add_exact_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    accept && !up.op_mul |=> !precision_lost
  ) else $error("precision_lost set on an add result");

  // output slot empty right after any reset cycle
  reset_clears_a: assert property (
    @(posedge clk) !rst_n |=> !out_valid
  ) else $error("out_valid high after reset");

endmodule

/* logic/fx_arith_top.sv */
// ################################################
// Top of the 8.8 fixed-point add/multiply pipeline.
// Operand pairs enter on a valid/ready stream, and
// results leave two cycles later with their flags.
// ################################################

`timescale 1ns/1ns

module fx_arith_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  fx_pkg::fx_word_t num_a,    // multiplicand or first addend
  input  fx_pkg::fx_word_t num_b,    // multiplier or second addend
  input  logic             op_mul,
  output logic             out_valid,
  input  logic             out_ready,
  output fx_pkg::fx_word_t result,
  output logic             overflow,
  output logic             precision_lost
);

  // link between the two slots
  fx_stage_if i_stage_if ();

  fx_partial_stage i_partial_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .num_a    (num_a),
    .num_b    (num_b),
    .op_mul   (op_mul),
    .down     (i_stage_if.src)
  );

  fx_reduce_stage i_reduce_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .up             (i_stage_if.dst),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .result         (result),
    .overflow       (overflow),
    .precision_lost (precision_lost)
  );

endmodule

/* testbench/tb_fx_arith.sv */
// ################################################
// Testbench for the 8.8 fixed-point add/multiply
// pipeline. Drives operand pairs through the DUT,
// keeps expected results in a FIFO, and checks the
// outputs, latency and stall behavior by assertions.
// ################################################

`timescale 1ns/1ns

`include "fx_defs.svh"

module tb_fx_arith;
  import fx_pkg::*;

  localparam int N_ITEMS = 234;              // 6 + 40 + 8 + 40 + 20 + 120
  localparam int TIMEOUT = 2 * N_ITEMS + 100;

  logic     clk = 1'b0;
  logic     rst_n = 1'b0;
  logic     in_valid = 1'b0;
  logic     in_ready;
  fx_word_t num_a = '0;
  fx_word_t num_b = '0;
  logic     op_mul = 1'b0;
  logic     out_valid;
  logic     out_ready = 1'b1;
  fx_word_t result;
  logic     overflow;
  logic     precision_lost;

  integer   seed = 60926;
  int       cycle = 0;
  int       errors = 0;
  int       err_base = 0;
  int       n_tests = 0;
  int       in_count = 0;
  int       out_count = 0;
  logic     bp_mode = 1'b0;                  // random out_ready when set

  // expected results, in acceptance order
  fx_word_t   exp_res [256];
  logic       exp_ovf [256];
  logic       exp_lost [256];
  int         exp_cyc [256];                 // cycle of the accepting edge
  logic       exp_lat [256];                 // out_ready was held high
  logic [7:0] wr_ptr = '0;
  logic [7:0] rd_ptr = '0;

  fx_word_t head_res;
  logic     head_ovf;
  logic     head_lost;
  int       head_cyc;
  logic     head_lat;

  fx_arith_top i_fx_arith_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .num_a          (num_a),
    .num_b          (num_b),
    .op_mul         (op_mul),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .result         (result),
    .overflow       (overflow),
    .precision_lost (precision_lost)
  );

  initial
  begin
    forever #5 clk = ~clk;
  end

  // packs {result, overflow, precision_lost} from the format rules
  function automatic logic [17:0] model(input fx_word_t a, input fx_word_t b, input logic mul);
    logic [31:0] prod;
    logic [16:0] sum;
    prod = {16'h0000, a} * {16'h0000, b};
    sum  = {1'b0, a} + {1'b0, b};
    if (mul)
      model = {prod[23:8], |prod[31:24], |prod[7:0]};
    else
      model = {sum[15:0], sum[16], 1'b0};
  endfunction

  always @(posedge clk)
  begin
    logic [17:0] m;
    cycle <= cycle + 1;
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (in_valid && in_ready)
      begin
        m = model(num_a, num_b, op_mul);
        exp_res[wr_ptr]  <= m[17:2];
        exp_ovf[wr_ptr]  <= m[1];
        exp_lost[wr_ptr] <= m[0];
        exp_cyc[wr_ptr]  <= cycle;
        exp_lat[wr_ptr]  <= !bp_mode;
        wr_ptr           <= wr_ptr + 8'd1;
        in_count         <= in_count + 1;
      end
      if (out_valid && out_ready)
      begin
        rd_ptr    <= rd_ptr + 8'd1;
        out_count <= out_count + 1;
      end
    end
  end

  assign head_res  = exp_res[rd_ptr];
  assign head_ovf  = exp_ovf[rd_ptr];
  assign head_lost = exp_lost[rd_ptr];
  assign head_cyc  = exp_cyc[rd_ptr];
  assign head_lat  = exp_lat[rd_ptr];

  always @(posedge clk)
  begin
    logic [31:0] r;
    if (bp_mode)
    begin
      r = $random(seed);
      out_ready <= (r[1:0] != 2'b00); // high about 3 of 4 cycles
    end
    else
      out_ready <= 1'b1;
  end

  reset_valid_a: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
    else begin
      errors = errors + 1;
      $display("Error: %0t out_valid expected 0 got %b", $time, $sampled(out_valid));
    end

  reset_ready_a: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
    else begin
      errors = errors + 1;
      $display("Error: %0t in_ready expected 1 got %b", $time, $sampled(in_ready));
    end

  pending_a: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid && out_ready |-> wr_ptr != rd_ptr)
    else begin
      errors = errors + 1;
      $display("at %0t a result came out with no item pending", $time);
    end

  result_a: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid && out_ready |-> result == head_res)
    else begin
      errors = errors + 1;
      $display("Error: %0t result expected %h got %h", $time, $sampled(head_res),
               $sampled(result));
    end

  overflow_a: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid && out_ready |-> overflow == head_ovf)
    else begin
      errors = errors + 1;
      $display("Error: %0t overflow expected %b got %b", $time, $sampled(head_ovf),
               $sampled(overflow));
    end

  lost_a: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid && out_ready |-> precision_lost == head_lost)
    else begin
      errors = errors + 1;
      $display("Error: %0t precision_lost expected %b got %b", $time, $sampled(head_lost),
               $sampled(precision_lost));
    end

  latency_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && out_ready && head_lat |-> cycle - head_cyc == 2)
    else begin
      errors = errors + 1;
      $display("Error: %0t latency expected 2 got %0d", $time,
               $sampled(cycle) - $sampled(head_cyc));
    end

  stall_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=>
      out_valid && $stable(result) && $stable(overflow) && $stable(precision_lost))
    else begin
      errors = errors + 1;
      $display("at %0t the output changed or vanished while stalled", $time);
    end

  always @(posedge clk)
  begin
    if (cycle >= TIMEOUT)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Finished with errors");
      $finish;
    end
  end

  // holds the item until the accepting edge
  task automatic send_item(input fx_word_t a, input fx_word_t b, input logic mul);
    in_valid <= 1'b1;
    num_a    <= a;
    num_b    <= b;
    op_mul   <= mul;
    @(posedge clk);
    while (!in_ready)
      @(posedge clk);
  endtask

  task automatic send_random(input logic mul);
    logic [31:0] r;
    r = $random(seed);
    send_item(r[15:0], r[31:16], mul);
  endtask

  task automatic send_mixed(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++)
    begin
      r = $random(seed);
      send_random(r[0]);
    end
  endtask

  // bounded wait for the last results
  task automatic drain();
    in_valid <= 1'b0;
    @(posedge clk);
    for (int n = 0; n < 20 && wr_ptr != rd_ptr; n++)
      @(posedge clk);
    @(posedge clk);
  endtask

  task automatic end_test(input string name);
    $display("test %s done with %0d errors", name, errors - err_base);
    err_base = errors;
    n_tests  = n_tests + 1;
  endtask

  initial
  begin
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    end_test("reset");

    send_item(16'hFFFF, 16'h0001, 1'b0); // wraps to zero with carry
    send_item(16'h8000, 16'h8000, 1'b0);
    send_item(16'h0000, 16'h0000, 1'b0);
    send_item(16'h1234, 16'h4321, 1'b0);
    send_item(16'h7FFF, 16'h0001, 1'b0);
    send_item(16'hFFFF, 16'hFFFF, 1'b0);
    for (int i = 0; i < 40; i++)
      send_random(1'b0);
    drain();
    end_test("addition");

    send_item(16'h0100, 16'h1234, 1'b1); // 1.0 times x
    send_item(16'h5678, 16'h0100, 1'b1);
    send_item(16'h0080, 16'h0080, 1'b1); // fraction bits only
    send_item(16'h00FF, 16'h00FF, 1'b1);
    send_item(16'h0001, 16'h0001, 1'b1);
    send_item(16'h7F00, 16'h0200, 1'b1); // large integer parts
    send_item(16'hFFFF, 16'hFFFF, 1'b1);
    send_item(16'h0000, 16'hABCD, 1'b1);
    for (int i = 0; i < 40; i++)
      send_random(1'b1);
    drain();
    end_test("multiplication");

    send_mixed(20); // back to back
    drain();
    end_test("latency");

    bp_mode <= 1'b1;
    send_mixed(120);
    drain();
    bp_mode <= 1'b0;
    end_test("back-pressure");

    count_a: assert (in_count == N_ITEMS && out_count == in_count && wr_ptr == rd_ptr)
      else begin
        errors = errors + 1;
        $display("item counts do not match, %0d sent, %0d accepted, %0d returned",
                 N_ITEMS, in_count, out_count);
      end

    $display("tests %0d, items %0d, errors %0d", n_tests, out_count, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
logic/fx_pkg.sv
logic/fx_stage_if.sv
logic/fx_partial_stage.sv
logic/fx_reduce_stage.sv
logic/fx_arith_top.sv
testbench/tb_fx_arith.sv

/* run_sim.sh */
#!/bin/sh
# compiles the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_fx_arith -f sim.f

out=$(./obj_dir/Vtb_fx_arith)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
else
  exit 1
fi
